/* hdl/cout_config.svh */
`ifndef COUT_CONFIG_SVH
`define COUT_CONFIG_SVH

// fixed board configuration for the turfio to turf cout path

// number of surf cout lanes on this turfio
`define COUT_NUM_SURF 7

// clocks per response phase, one 32-bit word per phase at 4 bits per clock
`define COUT_PHASE_LEN 8

// phase at which the next word is taken into the hold register
`define COUT_LOAD_PHASE 7

// training pattern sent on couttio, and on all surf lanes in training
`define COUT_TRAIN_WORD 32'hA55A6996

// polarity of the couttio lane, set means the pair is swapped on the board
`define COUT_COUTTIO_INV 1'b0

// per-lane polarity of the surf lanes, bit i is lane i
`define COUT_SURF_INV 7'b000_0000

`endif

/* hdl/cout_pkg.sv */
`default_nettype none

`include "cout_config.svh"

package cout_pkg;

    // phase counter width follows the phase length
    localparam int unsigned COUT_PHASE_W = $clog2(`COUT_PHASE_LEN);

    typedef logic [COUT_PHASE_W-1:0] cout_phase_t;

    // one serializer nibble, bit 0 goes out first
    typedef logic [3:0] cout_nib_t;

    // tracker to shifter timing
    typedef struct packed {
        cout_phase_t phase;
        logic        load;
    } cout_timing_t;

    // response word
    // loaded as a whole word, read out one nibble at a time
    typedef union packed {
        logic [31:0]        word;
        cout_nib_t [7:0]    nib;
    } cout_word_u;

    // output lane bundle, one parallel nibble per lane
    typedef struct packed {
        cout_nib_t                          couttio;
        cout_nib_t [`COUT_NUM_SURF-1:0]     surf;
    } cout_lanes_t;

endpackage

`default_nettype wire

/* hdl/cout_phase_tracker.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cout_config.svh"

module cout_phase_tracker
    import cout_pkg::*;
(
    // system clock and async reset
    input  wire logic   sysclk_i,
    input  wire logic   arst_n_i,
    // one-cycle strobe marking cycle 0 of the sync period
    input  wire logic   sync_i,
    // phase and load strobe to the shifter
    output cout_timing_t timing_o
);

    // response phase counter
    cout_phase_t phase_q;

    // sync marks cycle 0, so the cycle after it is phase 1
    // otherwise count modulo the phase length
    always_ff @(posedge sysclk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            phase_q <= '0;
        end else if (sync_i) begin
            phase_q <= cout_phase_t'(1);
        end else if (phase_q == cout_phase_t'(`COUT_PHASE_LEN - 1)) begin
            phase_q <= '0;
        end else begin
            phase_q <= phase_q + 1'b1;
        end
    end

    // load decode is combinational off the counter
    // the shifter takes the new word on the edge that ends this phase
    assign timing_o = '{
        phase: phase_q,
        load:  (phase_q == cout_phase_t'(`COUT_LOAD_PHASE))
    };

    // a load is always followed by phase 0 or phase 1, never by another load
    // this keeps each word on the lane for at least six nibbles
    a_load_not_back_to_back: assert property (
        @(posedge sysclk_i) disable iff (!arst_n_i)
        timing_o.load |=> !timing_o.load
    );

endmodule

`default_nettype wire

/* hdl/cout_response_shifter.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cout_config.svh"

module cout_response_shifter
    import cout_pkg::*;
(
    // system clock and async reset
    input  wire logic           sysclk_i,
    input  wire logic           arst_n_i,
    // phase and load strobe from the tracker
    input  wire cout_timing_t   timing_i,
    // training level, picks the fixed pattern at the next load
    input  wire logic           train_i,
    // response word, only looked at on load edges
    input  wire logic [31:0]    response_i,
    // current nibble toward the lanes
    output cout_nib_t           tx_nib_o
);

    // word being sent, low nibble is on the wire
    cout_word_u hold_q;

    // word to take at the next load
    logic [31:0] load_word;

    // training pattern wins over the response word
    assign load_word = train_i ? `COUT_TRAIN_WORD : response_i;

    always_ff @(posedge sysclk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hold_q <= '0;
        end else if (timing_i.load) begin
            hold_q.word <= load_word;
        end else begin
            // one nibble per clock, lsb first, zeros fill from the top
            hold_q.word <= {4'h0, hold_q.word[31:4]};
        end
    end

    assign tx_nib_o = hold_q.nib[0];

    // loads are at least seven edges apart, even when sync cuts a phase short
    // so six shifts have cleared all but the two low nibbles by the next load
    a_word_drained_at_load: assert property (
        @(posedge sysclk_i) disable iff (!arst_n_i)
        timing_i.load |-> (hold_q.nib[7:2] == '0)
    );

endmodule

`default_nettype wire

/* hdl/cout_lane_driver.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cout_config.svh"

module cout_lane_driver
    import cout_pkg::*;
(
    // system clock and async reset
    input  wire logic                           sysclk_i,
    input  wire logic                           arst_n_i,
    // training level, surf lanes follow couttio while high
    input  wire logic                           train_i,
    // shared nibble from the shifter
    input  wire cout_nib_t                      tx_nib_i,
    // surf responses, lane i in bits 4i to 4i+3
    input  wire logic [4*`COUT_NUM_SURF-1:0]    surf_response_i,
    // registered lane nibbles, polarity already applied
    output cout_lanes_t                         lanes_o
);

    // polarity masks for this board
    localparam logic            couttio_inv = `COUT_COUTTIO_INV;
    localparam logic [`COUT_NUM_SURF-1:0] surf_inv = `COUT_SURF_INV;

    // idle bundle is all zeros after polarity, i.e. just the masks
    function automatic cout_lanes_t idle_lanes();
        cout_lanes_t idle;
        idle.couttio = {4{couttio_inv}};
        for (int i = 0; i < `COUT_NUM_SURF; i++) begin
            idle.surf[i] = {4{surf_inv[i]}};
        end
        return idle;
    endfunction

    localparam cout_lanes_t lanes_idle = idle_lanes();

    // next lane values
    cout_lanes_t lanes_d;

    always_comb begin
        // couttio always carries the shifter nibble
        lanes_d.couttio = tx_nib_i ^ {4{couttio_inv}};
        for (int i = 0; i < `COUT_NUM_SURF; i++) begin
            // in training every surf lane mirrors couttio so the
            // receiver can align all lanes off the same pattern
            lanes_d.surf[i] = (train_i ? tx_nib_i : surf_response_i[4*i +: 4])
                              ^ {4{surf_inv[i]}};
        end
    end

    // one register stage for every lane, stands in for the serializer input
    always_ff @(posedge sysclk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            lanes_o <= lanes_idle;
        end else begin
            lanes_o <= lanes_d;
        end
    end

    // an unknown train level would put x on all surf lanes at once
    a_train_known: assert property (
        @(posedge sysclk_i) disable iff (!arst_n_i)
        !$isunknown(train_i)
    );

endmodule

`default_nettype wire

/* hdl/turf_cout_top.sv */
`timescale 1ns/1ns
`default_nettype none

module turf_cout_top
    import cout_pkg::*;
(
    // system clock and async reset
    input  wire logic           sysclk_i,
    input  wire logic           arst_n_i,
    // training enable for all lanes
    input  wire logic           train_i,
    // marks cycle 0 of the sync period
    input  wire logic           sync_i,
    // response word, sampled at the load phase
    input  wire logic [31:0]    response_i,
    // surf responses, seven nibbles, reclocked straight out
    input  wire logic [27:0]    surf_response_i,
    // parallel lane nibbles toward the serializers
    output cout_lanes_t         lanes_o
);

    // tracker to shifter
    cout_timing_t timing;

    // shifter to lane driver
    cout_nib_t tx_nib;

    // phase counter and load strobe
    cout_phase_tracker i_cout_phase_tracker (
        .sysclk_i (sysclk_i),
        .arst_n_i (arst_n_i),
        .sync_i   (sync_i),
        .timing_o (timing)
    );

    // couttio word hold and nibble shift
    cout_response_shifter i_cout_response_shifter (
        .sysclk_i   (sysclk_i),
        .arst_n_i   (arst_n_i),
        .timing_i   (timing),
        .train_i    (train_i),
        .response_i (response_i),
        .tx_nib_o   (tx_nib)
    );

    // lane select, polarity and output register
    cout_lane_driver i_cout_lane_driver (
        .sysclk_i        (sysclk_i),
        .arst_n_i        (arst_n_i),
        .train_i         (train_i),
        .tx_nib_i        (tx_nib),
        .surf_response_i (surf_response_i),
        .lanes_o         (lanes_o)
    );

endmodule

`default_nettype wire

/* sim/cout_clk_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module cout_clk_gen (
    // free-running sysclk
    output logic sysclk_o,
    // async reset, low for the first two rising edges
    output logic arst_n_o
);

    // 4 ns period
    localparam int half_period = 2;

    initial begin
        sysclk_o = 1'b0;
        forever #half_period sysclk_o = ~sysclk_o;
    end

    // release lands 1 ns after an edge, like every other input
    initial begin
        arst_n_o = 1'b0;
        repeat (2) @(posedge sysclk_o);
        #1;
        arst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

/* sim/cout_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cout_config.svh"

module cout_tb
    import cout_pkg::*;
();

    // lane polarity as it leaves the design
    localparam logic                      couttio_mask = `COUT_COUTTIO_INV;
    localparam logic [`COUT_NUM_SURF-1:0] surf_mask    = `COUT_SURF_INV;

    // random traffic length and the cycle of the mid-run reset
    localparam int num_cycles  = 1500;
    localparam int reset_cycle = 700;
    // longest wait for any event, in cycles
    localparam int wait_limit  = 32;

    logic        sysclk;
    logic        gen_rst_n;
    logic        pulse_rst_n;
    logic        arst_n;
    logic        train;
    logic        sync;
    logic [31:0] response;
    logic [27:0] surf_response;
    cout_lanes_t lanes;

    // lcg state, cycles left in the current train run
    logic [31:0] rng_state;
    int          train_left;

    // cycle model of phase counter, hold word and output register
    int          m_phase;
    logic [31:0] m_hold;
    cout_lanes_t m_lanes;
    logic        m_load_edge;

    // levels seen at the last rising edge
    logic        rst_at_edge;
    logic        train_at_edge;

    // reset from the generator or from a mid-run pulse
    assign arst_n = gen_rst_n & pulse_rst_n;

    cout_clk_gen i_cout_clk_gen (
        .sysclk_o (sysclk),
        .arst_n_o (gen_rst_n)
    );

    turf_cout_top i_turf_cout_top (
        .sysclk_i        (sysclk),
        .arst_n_i        (arst_n),
        .train_i         (train),
        .sync_i          (sync),
        .response_i      (response),
        .surf_response_i (surf_response),
        .lanes_o         (lanes)
    );

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // idle lanes are zero nibbles after polarity
    function automatic cout_lanes_t masks_bundle();
        cout_lanes_t b;
        b.couttio = {4{couttio_mask}};
        for (int i = 0; i < `COUT_NUM_SURF; i++) begin
            b.surf[i] = {4{surf_mask[i]}};
        end
        return b;
    endfunction

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic reset_model();
        m_phase     = 0;
        m_hold      = 32'h0;
        m_lanes     = masks_bundle();
        m_load_edge = 1'b0;
    endtask

    // one rising edge, all next values from the values before the edge
    task automatic advance_model();
        logic        load;
        logic [31:0] hold_next;
        cout_lanes_t lanes_next;
        load = (m_phase == `COUT_LOAD_PHASE);
        lanes_next.couttio = m_hold[3:0] ^ {4{couttio_mask}};
        for (int i = 0; i < `COUT_NUM_SURF; i++) begin
            lanes_next.surf[i] = (train ? m_hold[3:0] : surf_response[4*i +: 4])
                                 ^ {4{surf_mask[i]}};
        end
        if (load) begin
            hold_next = train ? `COUT_TRAIN_WORD : response;
        end else begin
            hold_next = m_hold >> 4;
        end
        // sync marks cycle 0, the next cycle is phase 1
        if (sync) begin
            m_phase = 1;
        end else begin
            m_phase = (m_phase + 1) % `COUT_PHASE_LEN;
        end
        m_hold      = hold_next;
        m_lanes     = lanes_next;
        m_load_edge = load;
    endtask

    task automatic compare_lanes();
        assert (lanes.couttio === m_lanes.couttio) else
            stop_with_failure($sformatf("CHECK FAILED at %0t: couttio lane is %h, expected %h",
                                        $time, lanes.couttio, m_lanes.couttio));
        for (int i = 0; i < `COUT_NUM_SURF; i++) begin
            assert (lanes.surf[i] === m_lanes.surf[i]) else
                stop_with_failure($sformatf("CHECK FAILED at %0t: surf lane %0d is %h, expected %h",
                                            $time, i, lanes.surf[i], m_lanes.surf[i]));
        end
    endtask

    // in training each surf lane carries the model's couttio nibble
    task automatic check_training_mirror();
        for (int i = 0; i < `COUT_NUM_SURF; i++) begin
            assert ((lanes.surf[i] ^ {4{surf_mask[i]}})
                    === (m_lanes.couttio ^ {4{couttio_mask}})) else
                stop_with_failure($sformatf(
                    "CHECK FAILED at %0t: surf lane %0d does not carry the training nibble",
                    $time, i));
        end
    endtask

    // rising edge, model step, then check once the outputs have settled
    task automatic run_cycle();
        @(posedge sysclk);
        rst_at_edge   = arst_n;
        train_at_edge = train;
        if (rst_at_edge) begin
            advance_model();
        end else begin
            reset_model();
        end
        #1;
        compare_lanes();
        if (rst_at_edge && train_at_edge) begin
            check_training_mirror();
        end
    endtask

    // called 1 ns after an edge
    // surf_idle keeps surf lanes at zero and holds off sync
    task automatic drive_random_inputs(input bit surf_idle);
        logic [31:0] r;
        response = lcg_next();
        r = lcg_next();
        surf_response = surf_idle ? 28'h0 : r[31:4];
        r = lcg_next();
        // train in runs of a few dozen cycles
        if (train_left == 0) begin
            train      = r[30];
            train_left = 16 + int'(r[21:16]) % 40;
        end else begin
            train_left = train_left - 1;
        end
        // about one sync in sixteen cycles, any phase
        sync = !surf_idle && (r[27:24] == 4'h0);
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (!rst_at_edge) begin
            run_cycle();
            n++;
            if (n > wait_limit) begin
                stop_with_failure("reset was never released by the clock generator");
            end
        end
    endtask

    // lanes stay idle until nibble 0 of the first word leaves
    task automatic wait_first_load();
        int n;
        n = 0;
        do begin
            drive_random_inputs(1'b1);
            run_cycle();
            assert (lanes === masks_bundle()) else
                stop_with_failure($sformatf("CHECK FAILED at %0t: lanes not idle before first word",
                                            $time));
            n++;
            if (n > wait_limit) begin
                stop_with_failure("no load strobe came after reset");
            end
        end while (!m_load_edge);
    endtask

    // sync at edge s, load at s+7, nibble k of the new word after edge s+8+k
    task automatic check_sync_realign();
        logic [31:0] word;
        int          k;
        word     = lcg_next();
        train    = 1'b0;
        sync     = 1'b1;
        response = word;
        run_cycle();
        sync = 1'b0;
        for (k = 1; k <= 15; k++) begin
            run_cycle();
            if (k >= 8) begin
                assert ((lanes.couttio ^ {4{couttio_mask}}) === word[4*(k-8) +: 4]) else
                    stop_with_failure($sformatf("CHECK FAILED at %0t: nibble %0d after sync is %h",
                                                $time, k - 8, lanes.couttio));
            end
        end
    endtask

    // async reset in mid-run, the lanes drop to idle without waiting for an edge
    task automatic pulse_reset();
        pulse_rst_n = 1'b0;
        #1;
        reset_model();
        assert (lanes === masks_bundle()) else
            stop_with_failure($sformatf("CHECK FAILED at %0t: lanes not idle during reset", $time));
        run_cycle();
        drive_random_inputs(1'b1);
        run_cycle();
        pulse_rst_n = 1'b1;
        wait_first_load();
    endtask

    initial begin
        int cycle;
        rng_state     = 32'h86fb016f;
        train_left    = 0;
        pulse_rst_n   = 1'b1;
        train         = 1'b0;
        sync          = 1'b0;
        response      = 32'h0;
        surf_response = 28'h0;
        rst_at_edge   = 1'b0;
        train_at_edge = 1'b0;
        reset_model();
        wait_reset_release();
        wait_first_load();
        for (cycle = 0; cycle < num_cycles; cycle++) begin
            if (cycle == reset_cycle) begin
                pulse_reset();
            end else if (cycle % 97 == 50) begin
                check_sync_realign();
            end else begin
                drive_random_inputs(1'b0);
                run_cycle();
            end
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+hdl
hdl/cout_pkg.sv
hdl/cout_phase_tracker.sv
hdl/cout_response_shifter.sv
hdl/cout_lane_driver.sv
hdl/turf_cout_top.sv
sim/cout_clk_gen.sv
sim/cout_tb.sv

/* Bender.yml */
package:
  name: turf_cout

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/cout_pkg.sv
      - hdl/cout_phase_tracker.sv
      - hdl/cout_response_shifter.sv
      - hdl/cout_lane_driver.sv
      - hdl/turf_cout_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/cout_clk_gen.sv
      - sim/cout_tb.sv
